/* run.sh */
#!/bin/sh
# Build and run the SRAM testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sram_wrap \
    -f verilog.f

./obj_dir/Vtb_sram_wrap > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1

/* sram_block_1rw1r.sv */
module sram_block_1rw1r
    import sram_pkg::*;
#(
    parameter int  BLOCK_WORDS = 512,
    localparam int IDX_W       = $clog2(BLOCK_WORDS)
)
(
    input  logic             clk_i,

    // Read/write port, driven by the data side
    input  logic             rw_cs_i,
    input  logic             rw_we_i,
    input  be_t              rw_be_i,
    input  logic [IDX_W-1:0] rw_idx_i,
    input  data_t            rw_wdata_i,
    output data_t            rw_rdata_o,

    // Read-only port, driven by the instruction side
    input  logic             r_cs_i,
    input  logic [IDX_W-1:0] r_idx_i,
    output data_t            r_rdata_o
);

    data_t mem [BLOCK_WORDS];

    // Read/write port
    always_ff @(posedge clk_i)
    begin
        if (rw_cs_i)
        begin
            if (rw_we_i)
            begin
                for (int b = 0; b < BE_W; b++)
                begin
                    if (rw_be_i[b]) mem[rw_idx_i][b*8 +: 8] <= rw_wdata_i[b*8 +: 8];
                end
            end
            rw_rdata_o <= mem[rw_idx_i];  // Old word, also on a write
        end
    end

    // Read port sees the contents before any write of the same edge
    always_ff @(posedge clk_i)
    begin
        if (r_cs_i)
        begin
            r_rdata_o <= mem[r_idx_i];
        end
    end

endmodule

/* sram_pkg.sv */
package sram_pkg;

    // Bus geometry shared by both ports
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;  // One enable per byte lane

    // Byte address bits below the word index
    localparam int WORD_OFS = $clog2(BE_W);

    // Bus byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // One data word as seen on either port
    typedef logic [DATA_W-1:0] data_t;

    // Byte enables of the data port
    typedef logic [BE_W-1:0] be_t;

endpackage

/* sram_req_decode.sv */
module sram_req_decode
    import sram_pkg::*;
#(
    parameter addr_t   BASE_ADDR   = 32'h8000_0000,
    parameter int      NUM_BLOCKS  = 4,
    parameter int      BLOCK_WORDS = 512,
    localparam int     IDX_W       = $clog2(BLOCK_WORDS)
)
(
    input  logic                  d_req_i,
    input  logic                  d_we_i,
    input  addr_t                 d_addr_i,
    input  logic                  i_req_i,
    input  addr_t                 i_addr_i,
    output logic                  d_gnt_o,
    output logic                  i_gnt_o,
    output logic                  illegal_o,
    output logic [NUM_BLOCKS-1:0] d_cs_o,
    output logic [NUM_BLOCKS-1:0] i_cs_o,
    output logic [IDX_W-1:0]      d_widx_o,
    output logic [IDX_W-1:0]      i_widx_o,
    output logic                  d_wen_o
);

    localparam int BLK_W   = (NUM_BLOCKS > 1) ? $clog2(NUM_BLOCKS) : 1;
    localparam int BLK_LSB = WORD_OFS + IDX_W;  // First address bit of the block number

    // Window end is exclusive, kept in 33 bits so a window at the top of memory fits
    localparam logic [32:0] WIN_BYTES = 33'(NUM_BLOCKS) * 33'(BLOCK_WORDS) * 33'(1 << WORD_OFS);
    localparam logic [32:0] WIN_END   = {1'b0, BASE_ADDR} + WIN_BYTES;

    // Block bits are taken straight from the address, so the base must sit on
    // a boundary of the whole block-number range
    localparam logic [32:0] ALIGN_BYTES = 33'(1) << (BLK_LSB + BLK_W);
    localparam bit          WIN_ALIGNED = (({1'b0, BASE_ADDR} % ALIGN_BYTES) == 33'd0);

    logic             d_legal;
    logic             i_legal;
    logic [BLK_W-1:0] d_blk;
    logic [BLK_W-1:0] i_blk;

    function automatic logic in_window(input addr_t addr);
        return WIN_ALIGNED
            && ({1'b0, addr} >= {1'b0, BASE_ADDR})
            && ({1'b0, addr} < WIN_END);
    endfunction

    // No back-pressure
    assign d_gnt_o = d_req_i;
    assign i_gnt_o = i_req_i;

    assign d_legal = d_req_i && in_window(d_addr_i);
    assign i_legal = i_req_i && in_window(i_addr_i);

    assign illegal_o = (d_req_i && !d_legal) || (i_req_i && !i_legal);

    assign d_blk    = d_addr_i[BLK_LSB +: BLK_W];
    assign i_blk    = i_addr_i[BLK_LSB +: BLK_W];
    assign d_widx_o = d_addr_i[WORD_OFS +: IDX_W];
    assign i_widx_o = i_addr_i[WORD_OFS +: IDX_W];
    assign d_wen_o  = d_legal && d_we_i;  // Illegal writes never reach a block

    // One-hot selects, all zero when idle or illegal
    always_comb
    begin
        d_cs_o = '0;
        i_cs_o = '0;
        for (int i = 0; i < NUM_BLOCKS; i++)
        begin
            if (d_legal && d_blk == BLK_W'(i)) d_cs_o[i] = 1'b1;
            if (i_legal && i_blk == BLK_W'(i)) i_cs_o[i] = 1'b1;
        end
    end

endmodule

/* sram_resp_mux.sv */
module sram_resp_mux
    import sram_pkg::*;
#(
    parameter int NUM_BLOCKS = 4
)
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  d_req_i,
    input  logic                  i_req_i,
    input  logic [NUM_BLOCKS-1:0] d_cs_i,
    input  logic [NUM_BLOCKS-1:0] i_cs_i,
    input  data_t                 d_blk_rdata_i [NUM_BLOCKS],
    input  data_t                 i_blk_rdata_i [NUM_BLOCKS],

    output logic                  d_rvalid_o,
    output data_t                 d_rdata_o,
    output logic                  i_rvalid_o,
    output data_t                 i_rdata_o
);

    // Selects of the request cycle
    logic [NUM_BLOCKS-1:0] d_cs_q;
    logic [NUM_BLOCKS-1:0] i_cs_q;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            d_cs_q     <= '0;
            i_cs_q     <= '0;
            d_rvalid_o <= 1'b0;
            i_rvalid_o <= 1'b0;
        end
        else
        begin
            d_cs_q     <= d_cs_i;
            i_cs_q     <= i_cs_i;
            d_rvalid_o <= d_req_i;  // Every granted request answers, legal or not
            i_rvalid_o <= i_req_i;
        end
    end

    // Steer block data back, zero when nothing was selected
    always_comb
    begin
        d_rdata_o = '0;
        i_rdata_o = '0;
        for (int i = 0; i < NUM_BLOCKS; i++)
        begin
            if (d_cs_q[i]) d_rdata_o = d_blk_rdata_i[i];
            if (i_cs_q[i]) i_rdata_o = i_blk_rdata_i[i];
        end
    end

endmodule

/* sram_wrap.sv */
module sram_wrap
    import sram_pkg::*;
#(
    parameter addr_t BASE_ADDR   = 32'h8000_0000,
    parameter int    NUM_BLOCKS  = 4,
    parameter int    BLOCK_WORDS = 512
)
(
    input  logic  clk_i,
    input  logic  rst_n_i,

    // Data port
    input  logic  d_req_i,
    input  logic  d_we_i,
    input  be_t   d_be_i,
    input  addr_t d_addr_i,
    input  data_t d_wdata_i,
    output logic  d_gnt_o,
    output logic  d_rvalid_o,
    output data_t d_rdata_o,

    // Instruction port, read only
    input  logic  i_req_i,
    input  addr_t i_addr_i,
    output logic  i_gnt_o,
    output logic  i_rvalid_o,
    output data_t i_rdata_o,

    output logic  illegal_memory_o
);

    localparam int IDX_W = $clog2(BLOCK_WORDS);

    logic [NUM_BLOCKS-1:0] d_cs;
    logic [NUM_BLOCKS-1:0] i_cs;
    logic [IDX_W-1:0]      d_widx;
    logic [IDX_W-1:0]      i_widx;
    logic                  d_wen;
    data_t                 d_blk_rdata [NUM_BLOCKS];
    data_t                 i_blk_rdata [NUM_BLOCKS];

    sram_req_decode #(
        .BASE_ADDR   (BASE_ADDR),
        .NUM_BLOCKS  (NUM_BLOCKS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) sram_req_decode_inst (
        .d_req_i   (d_req_i),
        .d_we_i    (d_we_i),
        .d_addr_i  (d_addr_i),
        .i_req_i   (i_req_i),
        .i_addr_i  (i_addr_i),
        .d_gnt_o   (d_gnt_o),
        .i_gnt_o   (i_gnt_o),
        .illegal_o (illegal_memory_o),
        .d_cs_o    (d_cs),
        .i_cs_o    (i_cs),
        .d_widx_o  (d_widx),
        .i_widx_o  (i_widx),
        .d_wen_o   (d_wen)
    );

    // Block array, data side on the RW port and instruction side on the R port
    for (genvar g = 0; g < NUM_BLOCKS; g++)
    begin : gen_blocks
        sram_block_1rw1r #(
            .BLOCK_WORDS (BLOCK_WORDS)
        ) sram_block_inst (
            .clk_i      (clk_i),
            .rw_cs_i    (d_cs[g]),
            .rw_we_i    (d_wen),
            .rw_be_i    (d_be_i),
            .rw_idx_i   (d_widx),
            .rw_wdata_i (d_wdata_i),
            .rw_rdata_o (d_blk_rdata[g]),
            .r_cs_i     (i_cs[g]),
            .r_idx_i    (i_widx),
            .r_rdata_o  (i_blk_rdata[g])
        );
    end

    sram_resp_mux #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) sram_resp_mux_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .d_req_i       (d_req_i),
        .i_req_i       (i_req_i),
        .d_cs_i        (d_cs),
        .i_cs_i        (i_cs),
        .d_blk_rdata_i (d_blk_rdata),
        .i_blk_rdata_i (i_blk_rdata),
        .d_rvalid_o    (d_rvalid_o),
        .d_rdata_o     (d_rdata_o),
        .i_rvalid_o    (i_rvalid_o),
        .i_rdata_o     (i_rdata_o)
    );

endmodule

/* sram_wrap_chk.sv */
module sram_wrap_chk
(
    input logic clk_i,
    input logic rst_n_i,
    input logic d_req_i,
    input logic i_req_i,
    input logic d_gnt_o,
    input logic i_gnt_o,
    input logic d_rvalid_o,
    input logic i_rvalid_o,
    input logic illegal_memory_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Grant follows request with no back-pressure
    gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (d_gnt_o == d_req_i) && (i_gnt_o == i_req_i))
        else $error("gnt differs from req");

    // One-cycle response on both ports
    rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (d_rvalid_o == $past(d_req_i)) && (i_rvalid_o == $past(i_req_i)))
        else $error("rvalid is not the previous cycle req");

    no_rvalid_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (!d_rvalid_o && !i_rvalid_o))
        else $error("rvalid high during reset");

    quiet_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!d_req_i && !i_req_i) |-> !illegal_memory_o)
        else $error("illegal flag without a request");

endmodule

bind sram_wrap sram_wrap_chk sram_wrap_chk_inst (.*);

/* tb_sram_wrap.sv */
module tb_sram_wrap
    import sram_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t BASE_ADDR   = 32'h8000_0000;
    localparam int    NUM_BLOCKS  = 4;
    localparam int    BLOCK_WORDS = 512;
    localparam int    WIN_WORDS   = NUM_BLOCKS * BLOCK_WORDS;
    localparam addr_t WIN_END     = BASE_ADDR + addr_t'(WIN_WORDS * 4);  // Exclusive
    localparam addr_t BLK_BYTES   = addr_t'(BLOCK_WORDS * 4);
    localparam int    SEED        = 32'hc48bb32f;

    typedef struct packed {
        logic  d_req;
        logic  i_req;
        logic  d_we;
        be_t   d_be;
        addr_t d_addr;
        addr_t i_addr;
        data_t wdata;
        logic  rnd;          // Fill wdata at run time
        logic  exp_illegal;
    } step_t;

    logic  clk_i;
    logic  rst_n_i;
    logic  d_req_i;
    logic  d_we_i;
    be_t   d_be_i;
    addr_t d_addr_i;
    data_t d_wdata_i;
    logic  d_gnt_o;
    logic  d_rvalid_o;
    data_t d_rdata_o;
    logic  i_req_i;
    addr_t i_addr_i;
    logic  i_gnt_o;
    logic  i_rvalid_o;
    data_t i_rdata_o;
    logic  illegal_memory_o;

    step_t steps [$];
    data_t shadow [WIN_WORDS];  // Every window word as the bus should see it
    bit    table_ready;
    int    errors;
    int    checks;

    // Responses expected in the cycle after the request
    logic  d_pend;
    logic  i_pend;
    logic  d_chk_data;
    data_t d_exp;
    data_t i_exp;

    sram_wrap #(
        .BASE_ADDR   (BASE_ADDR),
        .NUM_BLOCKS  (NUM_BLOCKS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) sram_wrap_inst (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic check(input string name, input data_t act, input data_t exp);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic add_step(input logic dr, input logic ir, input logic we, input be_t be,
                            input addr_t da, input addr_t ia, input data_t wd,
                            input logic rnd, input logic ill);
        steps.push_back({dr, ir, we, be, da, ia, wd, rnd, ill});
    endtask

    function automatic bit in_window(input addr_t addr);
        return (addr >= BASE_ADDR) && (addr < WIN_END);
    endfunction

    function automatic int word_of(input addr_t addr);
        return int'((addr - BASE_ADDR) >> 2);
    endfunction

    task automatic build_table();
        addr_t b0;
        addr_t b1;
        addr_t b2;
        addr_t b3;
        b0 = BASE_ADDR;
        b1 = BASE_ADDR + BLK_BYTES;
        b2 = BASE_ADDR + 2 * BLK_BYTES;
        b3 = BASE_ADDR + 3 * BLK_BYTES;
        add_step(0, 0, 0, 4'h0, 32'h0, 32'h0, 32'h0, 0, 0);  // Idle after reset
        // Full words into every block first
        add_step(1, 0, 1, 4'hf, b0, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'hf, b1 + 32'h004, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'hf, b2 + 32'h008, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'hf, b3 + 32'h7fc, 32'h0, 32'h0, 1, 0);  // Last window word
        add_step(1, 0, 1, 4'hf, b0 + 32'h010, 32'h0, 32'h0, 1, 0);
        // Byte-masked writes on top
        add_step(1, 0, 1, 4'h3, b0, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'h8, b1 + 32'h004, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'h5, b2 + 32'h008, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 1, 4'h6, b3 + 32'h7fc, 32'h0, 32'h0, 1, 0);
        add_step(1, 0, 0, 4'h0, b0, 32'h0, 32'h0, 0, 0);
        add_step(1, 0, 0, 4'h0, b1 + 32'h004, 32'h0, 32'h0, 0, 0);
        add_step(1, 0, 0, 4'h0, b2 + 32'h008, 32'h0, 32'h0, 0, 0);
        add_step(1, 0, 0, 4'h0, b3 + 32'h7fc, 32'h0, 32'h0, 0, 0);
        // Instruction reads beside data traffic in another block
        add_step(1, 1, 1, 4'hf, b2 + 32'h008, b0, 32'h0, 1, 0);
        add_step(0, 1, 0, 4'h0, 32'h0, b2 + 32'h008, 32'h0, 0, 0);
        add_step(1, 1, 0, 4'h0, b1 + 32'h004, b3 + 32'h7fc, 32'h0, 0, 0);
        add_step(0, 1, 0, 4'h0, 32'h0, b1 + 32'h004, 32'h0, 0, 0);
        // Instruction side gets the old word of a same-cycle write
        add_step(1, 1, 1, 4'hf, b0 + 32'h010, b0 + 32'h010, 32'h0, 1, 0);
        add_step(0, 1, 0, 4'h0, 32'h0, b0 + 32'h010, 32'h0, 0, 0);
        add_step(1, 0, 0, 4'h0, b0 + 32'h010, 32'h0, 32'h0, 0, 0);
        // Illegal accesses whose two writes alias onto real words
        add_step(1, 0, 0, 4'h0, BASE_ADDR - 32'h4, 32'h0, 32'h0, 0, 1);
        add_step(1, 0, 1, 4'hf, BASE_ADDR - 32'h4, 32'h0, 32'h0, 1, 1);
        add_step(1, 0, 1, 4'hf, WIN_END, 32'h0, 32'h0, 1, 1);
        add_step(0, 1, 0, 4'h0, 32'h0, WIN_END, 32'h0, 0, 1);
        add_step(0, 1, 0, 4'h0, 32'h0, 32'h0000_0000, 32'h0, 0, 1);
        add_step(1, 1, 0, 4'h0, b1 + 32'h004, WIN_END + 32'h100, 32'h0, 0, 1);
        add_step(1, 1, 0, 4'h0, WIN_END - 32'h4, BASE_ADDR - 32'h4, 32'h0, 0, 1);
        // Aliased words must be untouched
        add_step(1, 1, 0, 4'h0, b0, b3 + 32'h7fc, 32'h0, 0, 0);
        add_step(0, 0, 0, 4'h0, 32'h0, 32'h0, 32'h0, 0, 0);
    endtask

    task automatic check_responses();
        check("d_rvalid_o", data_t'(d_rvalid_o), data_t'(d_pend));
        check("i_rvalid_o", data_t'(i_rvalid_o), data_t'(i_pend));
        if (d_chk_data) check("d_rdata_o", d_rdata_o, d_exp);
        if (i_pend) check("i_rdata_o", i_rdata_o, i_exp);
    endtask

    // Reads are predicted before the write of the same cycle lands
    task automatic predict(input step_t st);
        bit d_ok;
        bit i_ok;
        d_ok       = st.d_req && in_window(st.d_addr);
        i_ok       = st.i_req && in_window(st.i_addr);
        d_pend     = st.d_req;
        i_pend     = st.i_req;
        d_chk_data = st.d_req && !(d_ok && st.d_we);  // Write data return is not defined
        d_exp      = d_ok ? shadow[word_of(st.d_addr)] : '0;
        i_exp      = i_ok ? shadow[word_of(st.i_addr)] : '0;
        if (d_ok && st.d_we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (st.d_be[b]) shadow[word_of(st.d_addr)][b*8 +: 8] = st.wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic drive(input step_t st);
        d_req_i   = st.d_req;
        d_we_i    = st.d_we;
        d_be_i    = st.d_be;
        d_addr_i  = st.d_addr;
        d_wdata_i = st.wdata;
        i_req_i   = st.i_req;
        i_addr_i  = st.i_addr;
    endtask

    initial
    begin
        step_t st;
        void'($urandom(SEED));
        rst_n_i    = 1'b0;
        d_req_i    = 1'b0;
        d_we_i     = 1'b0;
        d_be_i     = '0;
        d_addr_i   = '0;
        d_wdata_i  = '0;
        i_req_i    = 1'b0;
        i_addr_i   = '0;
        d_pend     = 1'b0;
        i_pend     = 1'b0;
        d_chk_data = 1'b0;
        d_exp      = '0;
        i_exp      = '0;
        errors     = 0;
        checks     = 0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        foreach (steps[n])
        begin
            @(negedge clk_i);
            check_responses();  // Outputs of the previous request
            st = steps[n];
            if (st.rnd) st.wdata = $urandom;
            drive(st);
            #1;
            check("d_gnt_o", data_t'(d_gnt_o), data_t'(st.d_req));
            check("i_gnt_o", data_t'(i_gnt_o), data_t'(st.i_req));
            check("illegal_memory_o", data_t'(illegal_memory_o), data_t'(st.exp_illegal));
            predict(st);
        end
        @(negedge clk_i);
        check_responses();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Watchdog sized from the table length
    initial
    begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (16 + steps.size() + 20) * 8 * 2;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

/* verilog.f */
sram_pkg.sv
sram_req_decode.sv
sram_block_1rw1r.sv
sram_resp_mux.sv
sram_wrap.sv
sram_wrap_chk.sv
tb_sram_wrap.sv
